// ==== hw/sa_pkg.sv ====
`default_nettype none

package sa_pkg;

    // One data word whose products and sums wrap modulo 2^16
    typedef logic [15:0] word_t;

    // External opcode
    typedef enum logic [1:0] {
        op_idle        = 2'd0,
        op_load_weight = 2'd1,
        op_matmul      = 2'd2,
        op_self_test   = 2'd3
    } sa_op_t;

    // Command broadcast to every PE
    typedef enum logic [2:0] {
        pe_idle       = 3'd0,
        pe_load       = 3'd1,
        pe_mac        = 3'd2,
        pe_test_run   = 3'd3,
        pe_test_check = 3'd4
    } pe_mode_t;

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_run   = 2'd1,
        st_check = 2'd2,
        st_hold  = 2'd3   // Waits for op to leave op_self_test
    } st_state_t;

    typedef enum logic [1:0] {
        flt_none       = 2'd0,
        flt_flip_lsb   = 2'd1,
        flt_stuck_zero = 2'd2,
        flt_stuck_ones = 2'd3
    } fault_kind_t;

    typedef struct packed {
        logic done;
        logic pass;
    } st_status_t;

    // Fixed self-test case
    localparam word_t ST_MULT_A   = 16'h1234;
    localparam word_t ST_MULT_B   = 16'h0025;
    localparam word_t ST_ADD      = 16'h00A7;
    localparam word_t ST_EXPECTED = word_t'(ST_MULT_A * ST_MULT_B + ST_ADD);

endpackage

`default_nettype wire

// ==== hw/sa_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

module sa_issue #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              stall,
    input  sa_pkg::sa_op_t                   op,
    input  sa_pkg::word_t [ROWS-1:0]         left_in,
    input  sa_pkg::word_t [COLS-1:0]         top_in,
    output sa_pkg::pe_mode_t                 pe_mode,
    output sa_pkg::word_t [ROWS-1:0]         left_q,
    output sa_pkg::word_t [COLS-1:0]         top_q,
    output logic                             st_start
);

    import sa_pkg::*;

    st_state_t st_state;
    pe_mode_t  op_mode;

    // Plain opcodes map one to one onto PE commands
    always_comb begin
        case (op)
            op_load_weight: op_mode = pe_load;
            op_matmul:      op_mode = pe_mac;
            default:        op_mode = pe_idle;
        endcase
    end

    // Edge operands are registered alongside the command
    always_ff @(posedge clk) begin
        if (!stall) begin
            left_q <= left_in;
            top_q  <= top_in;
        end
    end

    // Self-test sequencer that also owns the PE command register
    always_ff @(posedge clk) begin
        if (rst) begin
            st_state <= st_idle;
            pe_mode  <= pe_idle;
            st_start <= 1'b0;
        end else if (!stall) begin
            st_start <= 1'b0;
            case (st_state)
                st_idle: begin
                    if (op == op_self_test) begin
                        st_state <= st_run;
                        pe_mode  <= pe_test_run;
                        st_start <= 1'b1;   // One pulse per accepted request
                    end else begin
                        pe_mode  <= op_mode;
                    end
                end
                st_run: begin
                    st_state <= st_check;
                    pe_mode  <= pe_test_check;
                end
                st_check: begin
                    st_state <= st_hold;
                    pe_mode  <= pe_idle;
                end
                default: begin
                    // Load and matmul stay blocked until the request drops
                    pe_mode <= pe_idle;
                    if (op != op_self_test)
                        st_state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/sa_pe.sv ====
`timescale 1ns/1ns
`default_nettype none

module sa_pe (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  stall,
    input  sa_pkg::pe_mode_t     pe_mode,
    input  sa_pkg::fault_kind_t  fault,
    input  sa_pkg::word_t        left_in,
    input  sa_pkg::word_t        top_in,
    output sa_pkg::word_t        right_out,
    output sa_pkg::word_t        bottom_out,
    output sa_pkg::st_status_t   status
);

    import sa_pkg::*;

    word_t weight;   // Stationary operand
    word_t test_q;   // Result captured during pe_test_run
    word_t mul_a;
    word_t mul_b;
    word_t add_op;
    word_t mac_sum;
    word_t mac_res;
    logic  test_sel;

    // Self-test shares the multiplier and adder with normal MAC
    assign test_sel = (pe_mode == pe_test_run);
    assign mul_a    = test_sel ? ST_MULT_A : left_in;
    assign mul_b    = test_sel ? ST_MULT_B : weight;
    assign add_op   = test_sel ? ST_ADD    : top_in;
    assign mac_sum  = add_op + mul_a * mul_b;

    // Fault model sits on the datapath output
    always_comb begin
        case (fault)
            flt_flip_lsb:   mac_res = mac_sum ^ word_t'(1);
            flt_stuck_zero: mac_res = '0;
            flt_stuck_ones: mac_res = '1;
            default:        mac_res = mac_sum;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            weight     <= '0;
            right_out  <= '0;
            bottom_out <= '0;
            status     <= '0;
        end else if (!stall) begin
            case (pe_mode)
                pe_load: begin
                    weight     <= top_in;
                    bottom_out <= top_in;   // Shift weight on to the next row
                end
                pe_mac: begin
                    right_out  <= left_in;
                    bottom_out <= mac_res;
                end
                pe_test_run: begin
                    status.done <= 1'b0;
                end
                pe_test_check: begin
                    status.done <= 1'b1;
                    status.pass <= (test_q == ST_EXPECTED);
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && test_sel)
            test_q <= mac_res;
    end

endmodule

`default_nettype wire

// ==== hw/sa_pe_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module sa_pe_array #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  wire                                       clk,
    input  wire                                       rst,
    input  wire                                       stall,
    input  sa_pkg::pe_mode_t                          pe_mode,
    input  sa_pkg::fault_kind_t [ROWS*COLS-1:0]       fault_inject,
    input  sa_pkg::word_t [ROWS-1:0]                  left_q,
    input  sa_pkg::word_t [COLS-1:0]                  top_q,
    output sa_pkg::word_t [ROWS-1:0]                  right_out,
    output sa_pkg::word_t [COLS-1:0]                  bottom_out,
    output sa_pkg::st_status_t [ROWS*COLS-1:0]        status
);

    import sa_pkg::*;

    // Column 0 of hor is the left edge, column COLS the right edge
    wire word_t hor [ROWS][COLS+1];
    // Row 0 of ver is the top edge, row ROWS the bottom edge
    wire word_t ver [ROWS+1][COLS];

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        assign hor[r][0]    = left_q[r];
        assign right_out[r] = hor[r][COLS];
    end

    for (genvar c = 0; c < COLS; c++) begin : g_edge
        assign ver[0][c]     = top_q[c];
        assign bottom_out[c] = ver[ROWS][c];
    end

    for (genvar r = 0; r < ROWS; r++) begin : g_pe_row
        for (genvar c = 0; c < COLS; c++) begin : g_pe_col
            // Fault and status buses are row-major
            sa_pe u_pe (
                .clk        (clk),
                .rst        (rst),
                .stall      (stall),
                .pe_mode    (pe_mode),
                .fault      (fault_inject[r*COLS + c]),
                .left_in    (hor[r][c]),
                .top_in     (ver[r][c]),
                .right_out  (hor[r][c+1]),
                .bottom_out (ver[r+1][c]),
                .status     (status[r*COLS + c])
            );
        end
    end

endmodule

`default_nettype wire

// ==== hw/sa_st_collect.sv ====
`timescale 1ns/1ns
`default_nettype none

module sa_st_collect #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  st_start,
    input  sa_pkg::st_status_t [ROWS*COLS-1:0]   status,
    output logic [ROWS*COLS-1:0]                 st_result,
    output logic [$clog2(ROWS*COLS+1)-1:0]       st_fault_count,
    output logic                                 st_complete
);

    import sa_pkg::*;

    localparam int N     = ROWS * COLS;
    localparam int CNT_W = $clog2(N + 1);

    logic [N-1:0]     done_vec;
    logic [N-1:0]     fail_vec;
    logic [CNT_W-1:0] fail_cnt;

    // Unpack status and count failing PEs
    always_comb begin
        fail_cnt = '0;
        for (int i = 0; i < N; i++) begin
            done_vec[i] = status[i].done;
            fail_vec[i] = ~status[i].pass;
            fail_cnt    = fail_cnt + CNT_W'(fail_vec[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            st_result      <= '0;
            st_fault_count <= '0;
            st_complete    <= 1'b0;
        end else if (st_start) begin
            st_result      <= '0;   // New test drops old results
            st_fault_count <= '0;
            st_complete    <= 1'b0;
        end else if (&done_vec && !st_complete) begin
            st_result      <= fail_vec;
            st_fault_count <= fail_cnt;
            st_complete    <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sa_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module sa_top #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  wire                                   clk,
    input  wire                                   rst,
    input  sa_pkg::sa_op_t                        op,
    input  wire                                   stall,
    input  sa_pkg::word_t [ROWS-1:0]              left_in,
    input  sa_pkg::word_t [COLS-1:0]              top_in,
    input  sa_pkg::fault_kind_t [ROWS*COLS-1:0]   fault_inject,
    output sa_pkg::word_t [ROWS-1:0]              right_out,
    output sa_pkg::word_t [COLS-1:0]              bottom_out,
    output logic [ROWS*COLS-1:0]                  st_result,
    output logic [$clog2(ROWS*COLS+1)-1:0]        st_fault_count,
    output logic                                  st_complete
);

    import sa_pkg::*;

    pe_mode_t                   pe_mode;
    word_t [ROWS-1:0]           left_q;
    word_t [COLS-1:0]           top_q;
    logic                       st_start;
    st_status_t [ROWS*COLS-1:0] status;

    // Input side
    sa_issue #(.ROWS(ROWS), .COLS(COLS)) u_issue (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .op       (op),
        .left_in  (left_in),
        .top_in   (top_in),
        .pe_mode  (pe_mode),
        .left_q   (left_q),
        .top_q    (top_q),
        .st_start (st_start)
    );

    sa_pe_array #(.ROWS(ROWS), .COLS(COLS)) u_array (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .pe_mode      (pe_mode),
        .fault_inject (fault_inject),
        .left_q       (left_q),
        .top_q        (top_q),
        .right_out    (right_out),
        .bottom_out   (bottom_out),
        .status       (status)
    );

    // Self-test result side
    sa_st_collect #(.ROWS(ROWS), .COLS(COLS)) u_collect (
        .clk            (clk),
        .rst            (rst),
        .st_start       (st_start),
        .status         (status),
        .st_result      (st_result),
        .st_fault_count (st_fault_count),
        .st_complete    (st_complete)
    );

endmodule

`default_nettype wire

// ==== tb/sa_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module sa_tb;

    import sa_pkg::*;

    localparam int ROWS       = 4;
    localparam int COLS       = 4;
    localparam int N          = ROWS * COLS;
    localparam int CNT_W      = $clog2(N + 1);
    localparam int ST_TIMEOUT = 20;   // Cycles allowed for one self-test

    logic                clk;
    logic                rst;
    sa_op_t              op;
    logic                stall;
    word_t [ROWS-1:0]    left_in;
    word_t [COLS-1:0]    top_in;
    fault_kind_t [N-1:0] fault_inject;
    word_t [ROWS-1:0]    right_out;
    word_t [COLS-1:0]    bottom_out;
    logic [N-1:0]        st_result;
    logic [CNT_W-1:0]    st_fault_count;
    logic                st_complete;

    logic [31:0] lcg_state = 32'd58;
    int          errors;
    int          tests_run;
    int          tests_failed;
    word_t       w [ROWS][COLS];   // Stationary weights by row and column
    word_t       x [ROWS];         // Activations of the current pass

    sa_top #(.ROWS(ROWS), .COLS(COLS)) UUT (
        .clk            (clk),
        .rst            (rst),
        .op             (op),
        .stall          (stall),
        .left_in        (left_in),
        .top_in         (top_in),
        .fault_inject   (fault_inject),
        .right_out      (right_out),
        .bottom_out     (bottom_out),
        .st_result      (st_result),
        .st_fault_count (st_fault_count),
        .st_complete    (st_complete)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // A stalled edge must leave both edge outputs untouched
    stall_freeze: assert property (@(posedge clk) disable iff (rst)
        stall |=> ($stable(right_out) && $stable(bottom_out)))
    else begin
        $display("Edge outputs changed on a stalled cycle");
        errors++;
    end

    function automatic word_t rand_word();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $finish;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, errors - err_before);
        end
    endtask

    task automatic apply_reset();
        for (int i = 0; i < 10; i++)
            @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("st_complete", st_complete, 0);
        check_value("st_result", st_result, 0);
        check_value("st_fault_count", st_fault_count, 0);
        for (int r = 0; r < ROWS; r++)
            check_value($sformatf("right_out[%0d]", r), right_out[r], 0);
        for (int c = 0; c < COLS; c++)
            check_value($sformatf("bottom_out[%0d]", c), bottom_out[c], 0);
    endtask

    // Weights go in last row first and two idle cycles let the last load land
    task automatic load_weights();
        for (int r = 0; r < ROWS; r++)
            for (int c = 0; c < COLS; c++)
                w[r][c] = rand_word();
        for (int k = 0; k < ROWS + 2; k++) begin
            @(posedge clk);
            if (k < ROWS) begin
                op <= op_load_weight;
                for (int c = 0; c < COLS; c++)
                    top_in[c] <= w[ROWS-1-k][c];
            end else begin
                op     <= op_idle;
                top_in <= '0;
            end
            @(negedge clk);
        end
        // Bottom row passes on its own weight
        for (int c = 0; c < COLS; c++)
            check_value($sformatf("bottom_out[%0d]", c), bottom_out[c], w[ROWS-1][c]);
    endtask

    // Skewed matmul pass with stall optionally held from cycle stall_at
    task automatic stream_matmul(input int stall_at, input int stall_len);
        word_t exp_col [COLS];
        logic  stalled;
        int    step;
        int    j;
        for (int r = 0; r < ROWS; r++)
            x[r] = rand_word();
        for (int c = 0; c < COLS; c++) begin
            exp_col[c] = '0;
            for (int r = 0; r < ROWS; r++)
                exp_col[c] = exp_col[c] + x[r] * w[r][c];
        end
        for (int k = 0; k <= ROWS + COLS + stall_len + 1; k++) begin
            @(posedge clk);
            stalled = (k >= stall_at) && (k < stall_at + stall_len);
            j       = (k < stall_at) ? k : k - stall_len;   // Step of the stream
            op     <= op_matmul;
            stall  <= stalled;
            top_in <= '0;   // Zero psums at the top edge
            for (int r = 0; r < ROWS; r++)
                left_in[r] <= (!stalled && j == r) ? x[r] : '0;
            @(negedge clk);
            // Frozen cycles are covered by the stall property
            if (k <= stall_at || k > stall_at + stall_len) begin
                step = (k <= stall_at) ? k : k - stall_len;
                for (int c = 0; c < COLS; c++)
                    if (step == ROWS + c + 1)
                        check_value($sformatf("bottom_out[%0d]", c), bottom_out[c],
                                    exp_col[c]);
                for (int r = 0; r < ROWS; r++)
                    if (step == r + COLS + 1)
                        check_value($sformatf("right_out[%0d]", r), right_out[r], x[r]);
            end
        end
        @(posedge clk);
        op      <= op_idle;
        stall   <= 1'b0;
        left_in <= '0;
    endtask

    task automatic request_self_test(input fault_kind_t [N-1:0] kinds);
        logic [N-1:0] exp_result;
        int           exp_count;
        int           k;
        logic         seen_low;
        exp_count = 0;
        seen_low  = 1'b0;
        for (int i = 0; i < N; i++) begin
            exp_result[i] = (kinds[i] != flt_none);   // Any fault is visible
            exp_count     = exp_count + exp_result[i];
        end
        for (k = 0; k <= ST_TIMEOUT; k++) begin
            @(posedge clk);
            op           <= op_self_test;
            fault_inject <= kinds;
            @(negedge clk);
            if (!st_complete)
                seen_low = 1'b1;   // Old completion has been cleared
            else if (seen_low)
                break;
        end
        if (k > ST_TIMEOUT) begin
            abort_run("Timeout waiting for st_complete to rise");
        end else begin
            check_value("st_complete latency", k, 4);
            check_value("st_result", st_result, exp_result);
            check_value("st_fault_count", st_fault_count, exp_count);
            // Hold the request a little, then release it
            repeat (2) @(posedge clk);
            op <= op_idle;
            @(posedge clk);
            fault_inject <= '0;
            @(negedge clk);
            check_value("st_result", st_result, exp_result);
        end
    endtask

    initial begin
        int                  mark;
        fault_kind_t [N-1:0] kinds;
        rst          = 1'b1;
        op           = op_idle;
        stall        = 1'b0;
        left_in      = '0;
        top_in       = '0;
        fault_inject = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        mark = errors;
        apply_reset();
        report_test("reset state", mark);

        mark = errors;
        load_weights();
        stream_matmul(0, 0);
        report_test("weight load and activation pass-through", mark);

        mark = errors;
        stream_matmul(0, 0);
        report_test("matmul", mark);

        mark = errors;
        request_self_test('0);
        report_test("self-test without faults", mark);

        mark = errors;
        for (int i = 0; i < N; i++)
            kinds[i] = (rand_word() % 3 == 0) ? fault_kind_t'(1 + rand_word() % 3) : flt_none;
        if (kinds == '0)
            kinds[rand_word() % N] = flt_stuck_zero;   // At least one faulty PE
        request_self_test(kinds);
        report_test("self-test with injected faults", mark);

        mark = errors;
        stream_matmul(3, 3);
        report_test("stall during matmul", mark);

        $display("Summary: %0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/sa_pkg.sv
hw/sa_issue.sv
hw/sa_pe.sv
hw/sa_pe_array.sv
hw/sa_st_collect.sv
hw/sa_top.sv
tb/sa_tb.sv

// ==== Bender.yml ====
package:
  name: sa_array

sources:
  - hw/sa_pkg.sv
  - hw/sa_issue.sv
  - hw/sa_pe.sv
  - hw/sa_pe_array.sv
  - hw/sa_st_collect.sv
  - hw/sa_top.sv
  - target: simulation
    files:
      - tb/sa_tb.sv
